// ==== design/hssi_tx_pkg.sv ====
package hssi_tx_pkg;

   // ------------------------------
   // beat geometry
   // ------------------------------

   // client side data word of one stream beat
   localparam int tdata_w = 64;

   // one keep bit per data byte
   localparam int tkeep_w = tdata_w / 8;

   // sideband from client to MAC port
   localparam int tuser_w = 10;

   // ------------------------------
   // stage style
   // ------------------------------

   // mode_skid has a registered ready and one extra beat of storage
   // mode_simple runs at full rate and passes ready through combinationally
   // mode_bubble runs at half rate with no ready path back through the stage
   // mode_bypass is plain wires
   typedef enum logic [1:0] {
      mode_skid   = 2'd0,
      mode_simple = 2'd1,
      mode_bubble = 2'd2,
      mode_bypass = 2'd3
   } pl_mode_e;

endpackage

// ==== design/tx_axis_if.sv ====
`timescale 1ns/10ps

interface tx_axis_if (
   input logic clk,
   input logic rst
);

   // ------------------------------
   // beat from the source
   // ------------------------------
   logic                            tvalid;
   logic [hssi_tx_pkg::tdata_w-1:0] tdata;
   logic [hssi_tx_pkg::tkeep_w-1:0] tkeep;  // byte enables
   logic                            tlast;  // end of packet
   logic [hssi_tx_pkg::tuser_w-1:0] tuser;

   // back-pressure from the sink
   logic                            tready;

   // upstream side of a link
   modport src (
      input  clk,
      input  rst,
      output tvalid,
      output tdata,
      output tkeep,
      output tlast,
      output tuser,
      input  tready
   );

   // downstream side of a link
   modport snk (
      input  clk,
      input  rst,
      input  tvalid,
      input  tdata,
      input  tkeep,
      input  tlast,
      input  tuser,
      output tready
   );

endinterface

// ==== design/axis_register.sv ====
`timescale 1ns/10ps

module axis_register #(
   parameter hssi_tx_pkg::pl_mode_e MODE          = hssi_tx_pkg::mode_skid,
   parameter bit                    READY_RST_VAL = 1'b0
) (
   tx_axis_if.snk snk,
   tx_axis_if.src src
);

   // packed beat with data on top and tuser at the bottom
   localparam int beat_w = hssi_tx_pkg::tdata_w + hssi_tx_pkg::tkeep_w + 1
                           + hssi_tx_pkg::tuser_w;

   logic              clk;
   logic              rst;
   logic [beat_w-1:0] snk_beat;
   logic              out_valid;   // output register occupied
   logic [beat_w-1:0] out_beat;
   logic              out_open;    // output register can take a beat this cycle

   assign clk = snk.clk;
   assign rst = snk.rst;

   assign snk_beat = {snk.tdata, snk.tkeep, snk.tlast, snk.tuser};

   assign src.tvalid = out_valid;
   assign {src.tdata, src.tkeep, src.tlast, src.tuser} = out_beat;

   assign out_open = !out_valid || src.tready;

   generate
      if (MODE == hssi_tx_pkg::mode_skid) begin : g_skid

         // ------------------------------
         // skid buffer
         // ------------------------------
         logic              rdy_q;       // registered ready to upstream
         logic              skid_valid;
         logic [beat_w-1:0] skid_beat;
         logic              s_fire;

         assign snk.tready = rdy_q;
         assign s_fire     = snk.tvalid && rdy_q;

         // rdy_q is low exactly while the skid register holds a beat
         always_ff @(posedge clk) begin
            if (rst) begin
               out_valid  <= 1'b0;
               skid_valid <= 1'b0;
               rdy_q      <= READY_RST_VAL;
            end else if (out_open) begin
               out_valid  <= skid_valid || s_fire;   // skid drains first
               skid_valid <= 1'b0;
               rdy_q      <= 1'b1;
            end else if (s_fire) begin
               // downstream stalled while a beat came in
               skid_valid <= 1'b1;
               rdy_q      <= 1'b0;
            end
         end

         always_ff @(posedge clk) begin
            if (out_open) begin
               out_beat <= skid_valid ? skid_beat : snk_beat;
            end
            if (!out_open && s_fire) begin
               skid_beat <= snk_beat;
            end
         end

      end else if (MODE == hssi_tx_pkg::mode_simple ||
                   MODE == hssi_tx_pkg::mode_bubble) begin : g_single

         // ------------------------------
         // simple and bubble buffers
         // ------------------------------
         logic rdy_en;   // holds ready at its reset value until rst drops
         logic s_fire;

         // bubble only accepts into an empty register, so it never
         // needs the downstream ready on this path
         if (MODE == hssi_tx_pkg::mode_simple) begin : g_rdy_simple
            assign snk.tready = rdy_en && out_open;
         end else begin : g_rdy_bubble
            assign snk.tready = rdy_en && !out_valid;
         end

         assign s_fire = snk.tvalid && snk.tready;

         always_ff @(posedge clk) begin
            if (rst) begin
               out_valid <= 1'b0;
               rdy_en    <= READY_RST_VAL;
            end else begin
               rdy_en <= 1'b1;
               if (out_open) begin
                  out_valid <= s_fire;
               end
            end
         end

         always_ff @(posedge clk) begin
            if (s_fire) begin
               out_beat <= snk_beat;   // s_fire implies out_open here
            end
         end

      end else begin : g_bypass

         // ------------------------------
         // bypass with zero latency
         // ------------------------------
         assign snk.tready = src.tready;
         assign out_valid  = snk.tvalid;
         assign out_beat   = snk_beat;

      end
   endgenerate

   // ------------------------------
   // protocol checks
   // ------------------------------

   // once offered, a beat stays offered until downstream takes it
   a_valid_hold : assert property (
      @(posedge clk) disable iff (rst)
      src.tvalid && !src.tready |=> src.tvalid
   ) else $error("axis_register: tvalid dropped before the beat was taken");

   // nothing leaves the stage while it is held in reset
   a_valid_rst : assert property (
      @(posedge clk)
      rst && $past(rst) |-> !src.tvalid
   ) else $error("axis_register: tvalid high during reset");

endmodule

// ==== design/axis_tx_pipeline.sv ====
`timescale 1ns/10ps

module axis_tx_pipeline #(
   parameter hssi_tx_pkg::pl_mode_e MODE          = hssi_tx_pkg::mode_skid,
   parameter int                    PL_DEPTH      = 1,   // 0 to 8 stages
   parameter bit                    READY_RST_VAL = 1'b0
) (
   tx_axis_if.snk axis_s,   // from the client
   tx_axis_if.src axis_m    // toward the MAC port
);

   // links between stages where element n feeds stage n
   tx_axis_if axis_pl [PL_DEPTH:0] (
      .clk (axis_s.clk),
      .rst (axis_s.rst)
   );

   // ------------------------------
   // input end of the chain
   // ------------------------------
   assign axis_pl[0].tvalid = axis_s.tvalid;
   assign axis_pl[0].tdata  = axis_s.tdata;
   assign axis_pl[0].tkeep  = axis_s.tkeep;
   assign axis_pl[0].tlast  = axis_s.tlast;
   assign axis_pl[0].tuser  = axis_s.tuser;
   assign axis_s.tready     = axis_pl[0].tready;

   // ------------------------------
   // output end of the chain
   // ------------------------------
   // with PL_DEPTH of zero both ends land on element 0
   assign axis_m.tvalid            = axis_pl[PL_DEPTH].tvalid;
   assign axis_m.tdata             = axis_pl[PL_DEPTH].tdata;
   assign axis_m.tkeep             = axis_pl[PL_DEPTH].tkeep;
   assign axis_m.tlast             = axis_pl[PL_DEPTH].tlast;
   assign axis_m.tuser             = axis_pl[PL_DEPTH].tuser;
   assign axis_pl[PL_DEPTH].tready = axis_m.tready;

   // ------------------------------
   // register stages
   // ------------------------------
   genvar n;
   generate
      for (n = 0; n < PL_DEPTH; n++) begin : g_stage
         axis_register #(
            .MODE          (MODE),
            .READY_RST_VAL (READY_RST_VAL)
         ) axis_reg_inst (
            .snk (axis_pl[n]),
            .src (axis_pl[n+1])
         );
      end
   endgenerate

endmodule

// ==== design/hssi_tx_top.sv ====
`timescale 1ns/10ps

module hssi_tx_top #(
   parameter hssi_tx_pkg::pl_mode_e MODE          = hssi_tx_pkg::mode_skid,
   parameter int                    PL_DEPTH      = 1,
   parameter bit                    READY_RST_VAL = 1'b0
) (
   input  logic                            clk,
   input  logic                            rst,

   // client side
   input  logic                            s_tvalid,
   input  logic [hssi_tx_pkg::tdata_w-1:0] s_tdata,
   input  logic [hssi_tx_pkg::tkeep_w-1:0] s_tkeep,
   input  logic                            s_tlast,
   input  logic [hssi_tx_pkg::tuser_w-1:0] s_tuser,
   output logic                            s_tready,

   // MAC port side
   output logic                            m_tvalid,
   output logic [hssi_tx_pkg::tdata_w-1:0] m_tdata,
   output logic [hssi_tx_pkg::tkeep_w-1:0] m_tkeep,
   output logic                            m_tlast,
   output logic [hssi_tx_pkg::tuser_w-1:0] m_tuser,
   input  logic                            m_tready
);

   tx_axis_if axis_client (
      .clk (clk),
      .rst (rst)
   );

   tx_axis_if axis_mac (
      .clk (clk),
      .rst (rst)
   );

   // ------------------------------
   // plain ports into the client link
   // ------------------------------
   assign axis_client.tvalid = s_tvalid;
   assign axis_client.tdata  = s_tdata;
   assign axis_client.tkeep  = s_tkeep;
   assign axis_client.tlast  = s_tlast;
   assign axis_client.tuser  = s_tuser;
   assign s_tready           = axis_client.tready;   // READY_RST_VAL during reset

   // ------------------------------
   // MAC link back out to plain ports
   // ------------------------------
   assign m_tvalid        = axis_mac.tvalid;
   assign m_tdata         = axis_mac.tdata;
   assign m_tkeep         = axis_mac.tkeep;
   assign m_tlast         = axis_mac.tlast;
   assign m_tuser         = axis_mac.tuser;
   assign axis_mac.tready = m_tready;

   axis_tx_pipeline #(
      .MODE          (MODE),
      .PL_DEPTH      (PL_DEPTH),
      .READY_RST_VAL (READY_RST_VAL)
   ) axis_tx_pipeline_inst (
      .axis_s (axis_client),
      .axis_m (axis_mac)
   );

endmodule

// ==== bench/tb_tx_checker.sv ====
`timescale 1ns/10ps

module tb_tx_checker #(
   parameter int PL_DEPTH      = 3,
   parameter bit READY_RST_VAL = 1'b0,
   parameter int NUM_BEATS     = 400,
   parameter int STREAM_BEATS  = 100
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            s_tvalid,
   input  logic                            s_tready,
   input  logic                            m_tvalid,
   input  logic [hssi_tx_pkg::tdata_w-1:0] m_tdata,
   input  logic [hssi_tx_pkg::tkeep_w-1:0] m_tkeep,
   input  logic                            m_tlast,
   input  logic [hssi_tx_pkg::tuser_w-1:0] m_tuser,
   input  logic                            m_tready,
   input  int                              stim_idx,
   // data, keep, last and user packed in that order
   output logic [hssi_tx_pkg::tdata_w+hssi_tx_pkg::tkeep_w+hssi_tx_pkg::tuser_w:0] stim_beat,
   input  logic                            report,
   output int                              rx_count,
   output int                              err_total
);

   localparam int beat_w = hssi_tx_pkg::tdata_w + hssi_tx_pkg::tkeep_w + 1
                           + hssi_tx_pkg::tuser_w;

   int   err_reset = 0;
   int   err_data  = 0;
   int   err_lat   = 0;
   int   err_count = 0;
   int   cycle_cnt = 0;
   int   acc_q [$];       // acceptance cycle of each beat in flight
   logic rst_q = 1'b0;

   initial rx_count = 0;

   // expected content of beat k in 5 beat packets
   function automatic logic [beat_w-1:0] beat_ref(input int k);
      logic [31:0]                     k_word;
      logic [hssi_tx_pkg::tkeep_w-1:0] keep;
      int                              n_keep;
      k_word = k;
      keep   = '1;
      if (k % 5 == 4) begin
         n_keep = k % 8 + 1;
         keep   = ~({hssi_tx_pkg::tkeep_w{1'b1}} << n_keep);
      end
      return {k_word * 32'h9e37_79b9, k_word, keep, (k % 5 == 4),
              k_word[hssi_tx_pkg::tuser_w-1:0]};
   endfunction

   task automatic show_mismatch(input string test, input string field, input int k,
                                input logic [63:0] exp, input logic [63:0] act);
      err_data++;
      $display("mismatch %s beat %0d %s: expected %h, actual %h", test, k, field, exp, act);
   endtask

   assign stim_beat = beat_ref(stim_idx);
   assign err_total = err_reset + err_data + err_lat + err_count;

   // ------------------------------
   // monitor and compare
   // ------------------------------
   always @(posedge clk) begin : watch
      logic [beat_w-1:0]               exp_beat;
      logic [hssi_tx_pkg::tdata_w-1:0] exp_data;
      logic [hssi_tx_pkg::tkeep_w-1:0] exp_keep;
      logic                            exp_last;
      logic [hssi_tx_pkg::tuser_w-1:0] exp_user;
      int                              acc_cycle;
      string                           test_name;
      rst_q     <= rst;
      cycle_cnt <= cycle_cnt + 1;
      if (rst && rst_q) begin   // from the second reset edge on
         if (m_tvalid !== 1'b0) begin
            err_reset++;
            $display("mismatch reset m_tvalid: expected 0, actual %b", m_tvalid);
         end
         if (s_tready !== READY_RST_VAL) begin
            err_reset++;
            $display("mismatch reset s_tready: expected %b, actual %b",
                     READY_RST_VAL, s_tready);
         end
      end
      if (!rst && m_tvalid && m_tready) begin
         if (rx_count >= NUM_BEATS) begin
            err_count++;
            $display("an extra beat came out after all %0d beats were received", NUM_BEATS);
         end else begin
            exp_beat = beat_ref(rx_count);
            {exp_data, exp_keep, exp_last, exp_user} = exp_beat;
            if (rx_count < STREAM_BEATS) begin
               test_name = "stream";
            end else begin
               test_name = "backpressure";
            end
            if (m_tdata !== exp_data) begin
               show_mismatch(test_name, "tdata", rx_count, exp_data, m_tdata);
            end
            if (m_tkeep !== exp_keep) begin
               show_mismatch("sideband", "tkeep", rx_count, 64'(exp_keep), 64'(m_tkeep));
            end
            if (m_tlast !== exp_last) begin
               show_mismatch("sideband", "tlast", rx_count, 64'(exp_last), 64'(m_tlast));
            end
            if (m_tuser !== exp_user) begin
               show_mismatch("sideband", "tuser", rx_count, 64'(exp_user), 64'(m_tuser));
            end
            if (acc_q.size() == 0) begin
               err_count++;
               $display("beat %0d came out but was never accepted at the input", rx_count);
            end else begin
               acc_cycle = acc_q.pop_front();
               if (rx_count < STREAM_BEATS && cycle_cnt - acc_cycle != PL_DEPTH) begin
                  err_lat++;
                  $display("mismatch stream beat %0d latency: expected %0d, actual %0d",
                           rx_count, PL_DEPTH, cycle_cnt - acc_cycle);
               end
            end
         end
         rx_count <= rx_count + 1;
      end
      if (!rst && s_tvalid && s_tready) begin
         acc_q.push_back(cycle_cnt);
      end
   end

   always @(posedge report) begin
      $display("checker: %0d of %0d beats, errors reset %0d data %0d latency %0d count %0d",
               rx_count, NUM_BEATS, err_reset, err_data, err_lat, err_count);
   end

endmodule

// ==== bench/tb_hssi_tx.sv ====
`timescale 1ns/10ps

module tb_hssi_tx;

   localparam hssi_tx_pkg::pl_mode_e mode = hssi_tx_pkg::mode_skid;
   localparam int pl_depth      = 3;
   localparam bit ready_rst_val = 1'b0;
   localparam int num_beats     = 400;
   localparam int stream_beats  = 100;   // beats sent with no stalls
   localparam int timeout_lim   = num_beats * 4 + pl_depth + 100;
   localparam int beat_w = hssi_tx_pkg::tdata_w + hssi_tx_pkg::tkeep_w + 1
                           + hssi_tx_pkg::tuser_w;

   logic                            clk = 1'b0;
   logic                            rst = 1'b1;
   logic                            s_tvalid = 1'b0;
   logic [hssi_tx_pkg::tdata_w-1:0] s_tdata = '0;
   logic [hssi_tx_pkg::tkeep_w-1:0] s_tkeep = '0;
   logic                            s_tlast = 1'b0;
   logic [hssi_tx_pkg::tuser_w-1:0] s_tuser = '0;
   logic                            s_tready;
   logic                            m_tvalid;
   logic [hssi_tx_pkg::tdata_w-1:0] m_tdata;
   logic [hssi_tx_pkg::tkeep_w-1:0] m_tkeep;
   logic                            m_tlast;
   logic [hssi_tx_pkg::tuser_w-1:0] m_tuser;
   logic                            m_tready = 1'b0;

   logic [beat_w-1:0] stim_beat;          // reference beat for next_idx
   logic [15:0]       lfsr_q = 16'd8;
   logic              report = 1'b0;
   logic              timed_out = 1'b0;
   int                tx_idx = 0;         // beats accepted by the DUT
   int                next_idx;
   int                rx_count;
   int                err_total;
   int                cycle_cnt = 0;

   always #10 clk = ~clk;

   // 16 bit fibonacci with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic fb;
      fb = state[15] ^ state[13] ^ state[12] ^ state[10];
      return {state[14:0], fb};
   endfunction

   assign next_idx = tx_idx + ((s_tvalid && s_tready) ? 1 : 0);

   // ------------------------------
   // source and sink
   // ------------------------------
   always @(posedge clk) begin : drive_stream
      logic [15:0] lfsr_v;
      logic        valid_v;
      logic        ready_v;
      lfsr_v = lfsr_q;
      if (rst) begin
         s_tvalid <= 1'b0;
         m_tready <= 1'b0;
         tx_idx   <= 0;
      end else begin
         if (s_tvalid && s_tready) begin
            tx_idx <= next_idx;
         end
         // offer may only change once the current beat is taken
         if (!s_tvalid || s_tready) begin
            if (next_idx >= num_beats) begin
               valid_v = 1'b0;
            end else if (next_idx < stream_beats) begin
               valid_v = 1'b1;
            end else begin
               lfsr_v  = lfsr_next(lfsr_v);
               valid_v = lfsr_v[0];
            end
            s_tvalid <= valid_v;
            {s_tdata, s_tkeep, s_tlast, s_tuser} <= stim_beat;
         end
         if (rx_count < stream_beats) begin
            ready_v = 1'b1;
         end else begin
            lfsr_v  = lfsr_next(lfsr_v);
            ready_v = lfsr_v[0];   // random back-pressure
         end
         m_tready <= ready_v;
      end
      lfsr_q <= lfsr_v;
   end

   always @(posedge clk) begin
      if (!rst) begin
         cycle_cnt <= cycle_cnt + 1;
      end
   end

   // ------------------------------
   // run control
   // ------------------------------
   initial begin : run_ctrl
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      while (rx_count < num_beats && cycle_cnt < timeout_lim) begin
         @(posedge clk);
      end
      if (rx_count < num_beats) begin
         timed_out = 1'b1;
         $display("timeout: only %0d of %0d beats came out within %0d cycles",
                  rx_count, num_beats, timeout_lim);
      end else begin
         repeat (20) @(posedge clk);   // room for stray extra beats
      end
      report <= 1'b1;
      @(posedge clk);
      if (!timed_out && err_total == 0 && rx_count == num_beats) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   hssi_tx_top #(
      .MODE          (mode),
      .PL_DEPTH      (pl_depth),
      .READY_RST_VAL (ready_rst_val)
   ) hssi_tx_top_inst (
      .clk      (clk),
      .rst      (rst),
      .s_tvalid (s_tvalid),
      .s_tdata  (s_tdata),
      .s_tkeep  (s_tkeep),
      .s_tlast  (s_tlast),
      .s_tuser  (s_tuser),
      .s_tready (s_tready),
      .m_tvalid (m_tvalid),
      .m_tdata  (m_tdata),
      .m_tkeep  (m_tkeep),
      .m_tlast  (m_tlast),
      .m_tuser  (m_tuser),
      .m_tready (m_tready)
   );

   tb_tx_checker #(
      .PL_DEPTH      (pl_depth),
      .READY_RST_VAL (ready_rst_val),
      .NUM_BEATS     (num_beats),
      .STREAM_BEATS  (stream_beats)
   ) tb_tx_checker_inst (
      .clk       (clk),
      .rst       (rst),
      .s_tvalid  (s_tvalid),
      .s_tready  (s_tready),
      .m_tvalid  (m_tvalid),
      .m_tdata   (m_tdata),
      .m_tkeep   (m_tkeep),
      .m_tlast   (m_tlast),
      .m_tuser   (m_tuser),
      .m_tready  (m_tready),
      .stim_idx  (next_idx),
      .stim_beat (stim_beat),
      .report    (report),
      .rx_count  (rx_count),
      .err_total (err_total)
   );

endmodule

// ==== filelist.f ====
design/hssi_tx_pkg.sv
design/tx_axis_if.sv
design/axis_register.sv
design/axis_tx_pipeline.sv
design/hssi_tx_top.sv
bench/tb_tx_checker.sv
bench/tb_hssi_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TX pipeline testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

if ! verilator --binary --timing --assert -j 0 \
      --top-module tb_hssi_tx -f filelist.f; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_hssi_tx)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

if grep -qx "sim passed" <<< "$sim_out"; then
   exit 0
fi
exit 1
